//--- verilog.f
hw/video_pkg.sv
hw/scan_if.sv
hw/frame_resync.sv
hw/scan_timing.sv
hw/line_buffer.sv
hw/pixel_pipeline.sv
hw/video_timing_top.sv
tests/tb_clock.sv
tests/video_asserts.sv
tests/tb_video.sv

//--- Makefile
# Verilator build and run for the video scan-out testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       := tb_video
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
VECTORS   := tests/video_vectors.txt

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(VECTORS)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/video_vectors.txt
// Per frame: h_sync h_bp h_res h_fp v_sync v_bp v_res v_fp / depth words_per_line-1 /
// 16 palette entries (BGR) / words 0-1 of line 0 then of line 1 /
// expected RRGGBB of pixels 0-7 on line 0, then on line 1
// Frame 0, 4 bpp, one word per line
3 4 8 5 2 2 4 1
2 0
000 00F 0F0 F00 123 8A5 3C9 FFF 777 888 4E2 1B6 D0C 69A A5E 2F7
76543210 00000000 FEDCBA98 00000000
000000 FF0000 00FF00 0000FF 302010 50AF8F 9FCF30 FFFFFF
707070 8F8F8F 20EF40 60BF10 CF00DF AF9F60 EF50AF 70FF20
// Frame 1, 8 bpp with mixing, two words per line, palette reversed
4 3 8 7 1 3 3 2
3 1
2F7 A5E 69A D0C 1B6 4E2 888 777 FFF 3C9 8A5 123 F00 0F0 00F 000
452A1F00 B1F88763 E63E905C 19C4027D
703020 8F0000 506000 20AF40 40CF50 7030FF FFFFFF EF50AF
8F8F70 FF30AF FF4000 00CF8F 8FFF00 201060 60BF9F 9F0030

//--- tests/tb_video.sv
// Testbench for video_timing_top, driven from tests/video_vectors.txt.
// Each frame record holds geometry, depth, palette, two lines of words and
// the expected colour of the first 8 pixels of each of those lines.
// Lines beyond the second reuse the buffer half of the same parity.
// Inputs change on the falling edge, outputs are sampled there too.

`timescale 1ns/1ns

module tb_video;
   import video_pkg::*;

   localparam int NUM_FRAMES  = 2;
   localparam int MAX_WORDS   = 2;
   localparam int MAX_PIX     = 8;
   localparam int REC_LEN     = 46;
   localparam int OFS_DEPTH   = 8;
   localparam int OFS_WPL     = 9;
   localparam int OFS_PAL     = 10;
   localparam int OFS_WORDS   = 26;
   localparam int OFS_EXP     = 30;
   localparam int TIMEOUT     = 4000;
   localparam int IDLE_CYCLES = 40;

   logic              pclk, reset;
   logic              i_sync_req, o_sync_ack, i_flyback;
   logic [CTR_W-1:0]  i_h_res, i_h_fp, i_h_sync, i_h_bp;
   logic [CTR_W-1:0]  i_v_res, i_v_fp, i_v_sync, i_v_bp;
   pix_depth_e        i_depth;
   logic [7:0]        i_words_per_line_m1;
   logic              i_load;
   logic [WORD_W-1:0] i_load_data;
   palette_t          i_palette;
   logic [CHAN_W-1:0] o_r, o_g, o_b;
   logic              o_hsync, o_vsync, o_de;

   logic [31:0] vec [NUM_FRAMES*REC_LEN];

   tb_clock u_clock (.o_pclk (pclk), .o_reset (reset));

   video_timing_top u_dut (.*);

   //////////////////////////////////////////////////////////////////////
   // Reporting and compare tasks

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped after the first error");
   endtask

   task automatic check_level(input logic act, input logic exp, input string what);
      if (act !== exp)
         abort_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, act, exp));
   endtask

   task automatic check_ack(input logic act, input logic exp);
      if (act !== exp)
         abort_run($sformatf("Error at %0t ns: o_sync_ack is %b, expected %b",
                             $time, act, exp));
   endtask

   task automatic check_count(input logic [CTR_W-1:0] act, input logic [CTR_W-1:0] exp,
                              input string what);
      if (act !== exp)
         abort_run($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                             $time, what, act, exp));
   endtask

   task automatic check_rgb(input logic [CHAN_W-1:0] r, input logic [CHAN_W-1:0] g,
                            input logic [CHAN_W-1:0] b, input logic [3*CHAN_W-1:0] exp,
                            input string where);
      if ({r, g, b} !== exp)
         abort_run($sformatf("Error at %0t ns: RGB %h at %s, expected %h",
                             $time, {r, g, b}, where, exp));
   endtask

   function automatic logic [31:0] vec_field(input int f, input int ofs);
      return vec[f*REC_LEN + ofs];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Stimulus

   task automatic apply_config(input int f);
      logic [31:0] w;
      i_h_sync = CTR_W'(vec_field(f, 0));
      i_h_bp   = CTR_W'(vec_field(f, 1));
      i_h_res  = CTR_W'(vec_field(f, 2));
      i_h_fp   = CTR_W'(vec_field(f, 3));
      i_v_sync = CTR_W'(vec_field(f, 4));
      i_v_bp   = CTR_W'(vec_field(f, 5));
      i_v_res  = CTR_W'(vec_field(f, 6));
      i_v_fp   = CTR_W'(vec_field(f, 7));
      w = vec_field(f, OFS_DEPTH);
      i_depth = pix_depth_e'(w[1:0]);
      w = vec_field(f, OFS_WPL);
      i_words_per_line_m1 = w[7:0];
      for (int i = 0; i < PAL_ENTRIES; i++) begin
         w = vec_field(f, OFS_PAL + i);
         i_palette[i] = w[11:0];
      end
   endtask

   // Toggle the request, then pulse flyback every 8 cycles until acked
   task automatic resync();
      int cyc;
      i_sync_req = ~i_sync_req;
      cyc = 0;
      while (o_sync_ack !== i_sync_req) begin
         if (cyc == TIMEOUT)
            abort_run("Timeout: o_sync_ack never followed the request");
         i_flyback = (cyc % 8) < 4;
         @(negedge pclk);
         cyc++;
      end
      i_flyback = 1'b0;
   endtask

   // Two lines, at most MAX_WORDS words each
   task automatic load_lines(input int f);
      int wpl;
      wpl = vec_field(f, OFS_WPL) + 1;
      for (int l = 0; l < 2; l++) begin
         for (int w = 0; w < wpl; w++) begin
            i_load      = 1'b1;
            i_load_data = vec_field(f, OFS_WORDS + l*MAX_WORDS + w);
            @(negedge pclk);
         end
      end
      i_load = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Checks

   task automatic check_idle();
      for (int c = 0; c < IDLE_CYCLES; c++) begin
         check_level(o_de, 1'b0, "o_de");
         check_level(o_hsync, 1'b0, "o_hsync");
         check_level(o_vsync, 1'b0, "o_vsync");
         check_ack(o_sync_ack, 1'b0);
         @(negedge pclk);
      end
   endtask

   // Returns on the first sample with o_vsync high after a low one
   task automatic wait_frame_start();
      int   cyc;
      logic prev;
      cyc  = 0;
      prev = 1'b1;
      while (!(prev == 1'b0 && o_vsync == 1'b1)) begin
         if (cyc == TIMEOUT)
            abort_run("Timeout: no rising edge on o_vsync");
         prev = o_vsync;
         @(negedge pclk);
         cyc++;
      end
   endtask

   // Walks one whole frame and compares every cycle with the line/frame model
   task automatic check_frame(input int f);
      int          hs, hd, hr, h_tot, vs, vd, vr, v_tot;
      int          line, col, n, de_cnt, de_lines, vs_lines, last_rise;
      logic        exp_de, hs_prev;
      logic [31:0] word;
      hs       = vec_field(f, 0);
      hd       = hs + vec_field(f, 1);
      hr       = vec_field(f, 2);
      h_tot    = hd + hr + vec_field(f, 3);
      vs       = vec_field(f, 4);
      vd       = vs + vec_field(f, 5);
      vr       = vec_field(f, 6);
      v_tot    = vd + vr + vec_field(f, 7);
      de_cnt   = 0;
      de_lines = 0;
      vs_lines = 0;
      last_rise = 0;
      hs_prev  = 1'b0;
      for (int t = 0; t < h_tot * v_tot; t++) begin
         line   = t / h_tot;
         col    = t % h_tot;
         exp_de = line >= vd && line < vd + vr && col >= hd && col < hd + hr;
         check_level(o_hsync, col < hs, "o_hsync");
         check_level(o_vsync, line < vs, "o_vsync");
         check_level(o_de, exp_de, "o_de");
         if (exp_de) begin
            n = col - hd;
            de_cnt++;
            if (n < MAX_PIX) begin
               word = vec_field(f, OFS_EXP + ((line - vd) % 2) * MAX_PIX + n);
               check_rgb(o_r, o_g, o_b, word[23:0],
                         $sformatf("line %0d pixel %0d", line - vd, n));
            end
         end else begin
            check_rgb(o_r, o_g, o_b, '0, "blanking");
         end
         if (o_hsync && !hs_prev) begin
            if (t > 0)
               check_count(t - last_rise, h_tot, "cycles between o_hsync rises");
            last_rise = t;
         end
         hs_prev = o_hsync;
         if (col == 0 && o_vsync)
            vs_lines++;
         if (col == h_tot - 1 && de_cnt != 0) begin
            check_count(de_cnt, hr, "o_de cycles in a line");
            de_lines++;
            de_cnt = 0;
         end
         @(negedge pclk);
      end
      check_count(de_lines, vr, "lines with o_de");
      check_count(vs_lines, vs, "lines with o_vsync");
      // Next frame starts right away
      check_level(o_vsync, 1'b1, "o_vsync at the next frame");
      check_ack(o_sync_ack, i_sync_req);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      int cyc;
      i_sync_req          = 1'b0;
      i_flyback           = 1'b0;
      i_h_res             = '0;
      i_h_fp              = '0;
      i_h_sync            = '0;
      i_h_bp              = '0;
      i_v_res             = '0;
      i_v_fp              = '0;
      i_v_sync            = '0;
      i_v_bp              = '0;
      i_depth             = PD_1BPP;
      i_words_per_line_m1 = '0;
      i_load              = 1'b0;
      i_load_data         = '0;
      i_palette           = '0;
      $readmemh("tests/video_vectors.txt", vec);
      if (vec[0] === 32'h0 || $isunknown(vec[0]))
         abort_run("Could not read tests/video_vectors.txt");
      cyc = 0;
      while (reset !== 1'b0) begin
         if (cyc == TIMEOUT)
            abort_run("Timeout: reset was never released");
         @(negedge pclk);
         cyc++;
      end
      check_idle();
      // Second pass is a reconfiguration of a running scan
      for (int f = 0; f < NUM_FRAMES; f++) begin
         apply_config(f);
         resync();
         load_lines(f);
         wait_frame_start();
         check_frame(f);
      end
      if (u_dut.u_asserts.fail_count != 0) begin
         abort_run("A concurrent assertion failed during the run");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

//--- tests/video_asserts.sv
// Concurrent checks on the top-level outputs and the resync handshake.
// Bound into video_timing_top; all checks are idle while reset is high.

`timescale 1ns/1ns

module video_asserts (
   input logic pclk,
   input logic reset,
   input logic i_run,
   input logic i_sync_ack,
   input logic i_hsync,
   input logic i_de
);

   // Number of failed checks
   int fail_count = 0;

   // Ack moves only in the cycle that releases the scan
   ack_needs_release: assert property (@(posedge pclk) disable iff (reset)
      $changed(i_sync_ack) |-> $rose(i_run))
      else begin
         fail_count++;
         $error("o_sync_ack toggled while the scan was not released");
      end

   release_moves_ack: assert property (@(posedge pclk) disable iff (reset)
      $rose(i_run) |-> $changed(i_sync_ack))
      else begin
         fail_count++;
         $error("scan released without toggling o_sync_ack");
      end

   // Display window lies after the sync pulse
   no_de_in_hsync: assert property (@(posedge pclk) disable iff (reset)
      !(i_de && i_hsync))
      else begin
         fail_count++;
         $error("o_de and o_hsync high together");
      end

endmodule

bind video_timing_top video_asserts u_asserts (
   .pclk       (pclk),
   .reset      (reset),
   .i_run      (run),
   .i_sync_ack (o_sync_ack),
   .i_hsync    (o_hsync),
   .i_de       (o_de)
);

//--- tests/tb_clock.sv
// Clock and reset source for the testbench.
// pclk has a 40 ns period; reset is high for the first four rising edges.

`timescale 1ns/1ns

module tb_clock (
   output logic o_pclk,
   output logic o_reset
);

   initial begin
      o_pclk = 1'b0;
      forever #20 o_pclk = ~o_pclk;
   end

   initial begin
      o_reset = 1'b1;
      repeat (4) @(posedge o_pclk);
      o_reset <= 1'b0;
   end

endmodule

//--- hw/video_timing_top.sv
// Video timing and scan-out top level.
// All ports are in the pclk domain except i_flyback, which is asynchronous.
// Geometry, depth and words per line are sampled only during a resync.
// Outputs are registered and mutually aligned, 4 cycles after the scan.

`timescale 1ns/1ns

module video_timing_top #(
   parameter int ctr_w = video_pkg::CTR_W
) (
   input  logic                          pclk,
   input  logic                          reset,
   // Resync handshake
   input  logic                          i_sync_req,
   output logic                          o_sync_ack,
   input  logic                          i_flyback,
   // Geometry
   input  logic [ctr_w-1:0]              i_h_res,
   input  logic [ctr_w-1:0]              i_h_fp,
   input  logic [ctr_w-1:0]              i_h_sync,
   input  logic [ctr_w-1:0]              i_h_bp,
   input  logic [ctr_w-1:0]              i_v_res,
   input  logic [ctr_w-1:0]              i_v_fp,
   input  logic [ctr_w-1:0]              i_v_sync,
   input  logic [ctr_w-1:0]              i_v_bp,
   input  video_pkg::pix_depth_e         i_depth,
   input  logic [7:0]                    i_words_per_line_m1,
   // DMA line data
   input  logic                          i_load,
   input  logic [video_pkg::WORD_W-1:0]  i_load_data,
   input  video_pkg::palette_t           i_palette,
   // Display
   output logic [video_pkg::CHAN_W-1:0]  o_r,
   output logic [video_pkg::CHAN_W-1:0]  o_g,
   output logic [video_pkg::CHAN_W-1:0]  o_b,
   output logic                          o_hsync,
   output logic                          o_vsync,
   output logic                          o_de
);
   import video_pkg::*;

   logic              run;
   logic              flyback_fall;
   logic [WORD_W-1:0] rd_word;

   scan_if #(.ctr_w(ctr_w)) u_scan ();

   frame_resync u_resync (
      .pclk, .reset, .i_sync_req, .i_flyback, .o_sync_ack,
      .o_run          (run),
      .o_flyback_fall (flyback_fall)
   );

   scan_timing #(.ctr_w(ctr_w)) u_timing (
      .pclk, .reset,
      .i_run (run),
      .i_h_res, .i_h_fp, .i_h_sync, .i_h_bp,
      .i_v_res, .i_v_fp, .i_v_sync, .i_v_bp,
      .i_depth,
      .scan  (u_scan.source)
   );

   line_buffer u_lbuf (
      .pclk, .reset, .i_load, .i_load_data, .i_words_per_line_m1,
      .i_flyback_fall (flyback_fall),
      .scan           (u_scan.fetch),
      .o_rd_word      (rd_word)
   );

   pixel_pipeline u_pix (
      .pclk, .reset,
      .scan      (u_scan.sink),
      .i_rd_word (rd_word),
      .i_palette,
      .o_r, .o_g, .o_b, .o_hsync, .o_vsync, .o_de
   );

endmodule

//--- hw/pixel_pipeline.sv
// Pixel pipeline, stages 1 to 4 after the scan position.
// Stage 1 line-buffer word, 2 extracted pixel, 3 palette colour, 4 outputs.
// Pixels are packed least significant first in each word.
// The palette input is sampled live, so change it only outside display.

`timescale 1ns/1ns

module pixel_pipeline (
   input  logic                          pclk,
   input  logic                          reset,
   scan_if.sink                          scan,
   input  logic [video_pkg::WORD_W-1:0]  i_rd_word,
   input  video_pkg::palette_t           i_palette,
   output logic [video_pkg::CHAN_W-1:0]  o_r,
   output logic [video_pkg::CHAN_W-1:0]  o_g,
   output logic [video_pkg::CHAN_W-1:0]  o_b,
   output logic                          o_hsync,
   output logic                          o_vsync,
   output logic                          o_de
);
   import video_pkg::*;

   // Index suffix is the pipeline stage
   logic [4:0]  xidx1;
   pix_depth_e  depth1, depth2;
   logic [7:0]  pix2;
   pal_entry_t  entry2, mixed2, col3;
   logic [3:1]  hs_pipe, vs_pipe, de_pipe;

   // 4-bit channel to CHAN_W, top bit fills the low end
   function automatic logic [CHAN_W-1:0] expand(input logic [3:0] nib);
      return {nib, {(CHAN_W-4){nib[3]}}};
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Syncs delayed to stage 4

   always_ff @(posedge pclk) begin
      if (reset) begin
         hs_pipe <= '0;
         vs_pipe <= '0;
         de_pipe <= '0;
         o_hsync <= 1'b0;
         o_vsync <= 1'b0;
         o_de    <= 1'b0;
      end else begin
         hs_pipe <= {hs_pipe[2:1], scan.hsync};
         vs_pipe <= {vs_pipe[2:1], scan.vsync};
         de_pipe <= {de_pipe[2:1], scan.de};
         o_hsync <= hs_pipe[3];
         o_vsync <= vs_pipe[3];
         o_de    <= de_pipe[3];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Pixel data path

   // 8 bpp VIDC mixing, top four pixel bits override palette MSBs
   always_comb begin
      entry2 = i_palette[pix2[3:0]];
      mixed2 = entry2;
      if (depth2 == PD_8BPP) begin
         mixed2.red[3]     = pix2[4];
         mixed2.green[3:2] = pix2[6:5];
         mixed2.blue[3]    = pix2[7];
      end
   end

   always_ff @(posedge pclk) begin
      // Stage 0 to 1, alongside the buffer read
      xidx1  <= scan.dispx[4:0];
      depth1 <= scan.depth;

      // Stage 1 to 2, zero-extended so the low nibble is the palette index
      depth2 <= depth1;
      case (depth1)
         PD_1BPP: pix2 <= {7'd0, i_rd_word[xidx1]};
         PD_2BPP: pix2 <= {6'd0, i_rd_word[{xidx1[3:0], 1'b0} +: 2]};
         PD_4BPP: pix2 <= {4'd0, i_rd_word[{xidx1[2:0], 2'b00} +: 4]};
         default: pix2 <= i_rd_word[{xidx1[1:0], 3'b000} +: 8];
      endcase

      // Stage 2 to 3
      col3 <= mixed2;

      // Stage 3 to 4, black outside the display window
      o_r <= de_pipe[3] ? expand(col3.red)   : '0;
      o_g <= de_pipe[3] ? expand(col3.green) : '0;
      o_b <= de_pipe[3] ? expand(col3.blue)  : '0;
   end

endmodule

//--- hw/line_buffer.sv
// Double line buffer between the DMA and the pixel pipeline.
// DMA writes line n to half n%2 while half (n-1)%2 is scanned out.
// i_load is a strobe in the pclk domain, one word per cycle, no back-pressure.
// Read data is registered, one cycle after the scan position.

`timescale 1ns/1ns

module line_buffer (
   input  logic                          pclk,
   input  logic                          reset,
   input  logic                          i_load,
   input  logic [video_pkg::WORD_W-1:0]  i_load_data,
   input  logic [7:0]                    i_words_per_line_m1,
   input  logic                          i_flyback_fall,
   scan_if.fetch                         scan,
   output logic [video_pkg::WORD_W-1:0]  o_rd_word
);
   import video_pkg::*;

   // Word index within one half
   localparam int IDX_W = LB_ADDR_W - 1;

   logic [WORD_W-1:0]    mem [2*LB_HALF_WORDS];
   logic [LB_ADDR_W-1:0] wr_ptr;
   logic [IDX_W-1:0]     word_idx;
   logic [LB_ADDR_W-1:0] rd_addr;

   //////////////////////////////////////////////////////////////////////
   // DMA write side

   always_ff @(posedge pclk) begin
      if (reset || i_flyback_fall) begin
         // New frame always starts in half 0
         wr_ptr <= '0;
      end else if (i_load) begin
         if (wr_ptr[IDX_W-1:0] == i_words_per_line_m1)
            wr_ptr <= {~wr_ptr[LB_ADDR_W-1], {IDX_W{1'b0}}};
         else
            wr_ptr <= wr_ptr + 1'b1;
      end
   end

   always_ff @(posedge pclk) begin
      if (i_load)
         mem[wr_ptr] <= i_load_data;
   end

   //////////////////////////////////////////////////////////////////////
   // Scan read side

   // Pixels per word is 32, 16, 8 or 4
   always_comb begin
      case (scan.depth)
         PD_1BPP: word_idx = IDX_W'(scan.dispx >> 5);
         PD_2BPP: word_idx = IDX_W'(scan.dispx >> 4);
         PD_4BPP: word_idx = IDX_W'(scan.dispx >> 3);
         default: word_idx = IDX_W'(scan.dispx >> 2);
      endcase
   end

   assign rd_addr = {scan.line_odd, word_idx};

   always_ff @(posedge pclk)
      o_rd_word <= mem[rd_addr];

endmodule

//--- hw/scan_timing.sv
// Horizontal and vertical timing generator.
// Geometry and depth are latched only while i_run is low; hold for 3+ cycles.
// Each porch, sync and resolution value must be at least 1.
// Syncs are at the start of the scan: hsync from px 0, vsync from py 0.
// On release the scan starts at px 0 on the line before the first displayed one.

`timescale 1ns/1ns

module scan_timing #(
   parameter int ctr_w = video_pkg::CTR_W
) (
   input  logic                   pclk,
   input  logic                   reset,
   input  logic                   i_run,
   input  logic [ctr_w-1:0]       i_h_res,
   input  logic [ctr_w-1:0]       i_h_fp,
   input  logic [ctr_w-1:0]       i_h_sync,
   input  logic [ctr_w-1:0]       i_h_bp,
   input  logic [ctr_w-1:0]       i_v_res,
   input  logic [ctr_w-1:0]       i_v_fp,
   input  logic [ctr_w-1:0]       i_v_sync,
   input  logic [ctr_w-1:0]       i_v_bp,
   input  video_pkg::pix_depth_e  i_depth,
   scan_if.source                 scan
);
   import video_pkg::*;

   // Compare points, each the last count of its region
   logic [ctr_w-1:0] h_sync_off, h_disp_start, h_disp_end, h_total;
   logic [ctr_w-1:0] v_sync_off, v_disp_start, v_disp_end, v_total;
   pix_depth_e       depth_q;

   logic [ctr_w-1:0] px;
   logic [ctr_w-1:0] py;
   logic [ctr_w-1:0] dispx_q;
   logic             hsync_q;
   logic             vsync_q;
   logic             de_q;
   logic             v_on;
   logic             line_odd_q;

   //////////////////////////////////////////////////////////////////////
   // Configuration latch

   always_ff @(posedge pclk) begin
      if (!i_run) begin
         h_sync_off   <= i_h_sync - 1'b1;
         h_disp_start <= i_h_sync + i_h_bp - 1'b1;
         h_disp_end   <= i_h_sync + i_h_bp + i_h_res - 1'b1;
         h_total      <= i_h_sync + i_h_bp + i_h_res + i_h_fp - 1'b1;
         v_sync_off   <= i_v_sync - 1'b1;
         v_disp_start <= i_v_sync + i_v_bp - 1'b1;
         v_disp_end   <= i_v_sync + i_v_bp + i_v_res - 1'b1;
         v_total      <= i_v_sync + i_v_bp + i_v_res + i_v_fp - 1'b1;
         depth_q      <= i_depth;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Counters and syncs

   always_ff @(posedge pclk) begin
      if (reset) begin
         px         <= '0;
         py         <= '0;
         dispx_q    <= '0;
         hsync_q    <= 1'b0;
         vsync_q    <= 1'b0;
         de_q       <= 1'b0;
         v_on       <= 1'b0;
         line_odd_q <= 1'b0;
      end else if (!i_run) begin
         // Park at the last back-porch line; v_disp_start settles during the hold
         px         <= '0;
         py         <= v_disp_start;
         dispx_q    <= '0;
         hsync_q    <= 1'b1;
         vsync_q    <= 1'b0;
         de_q       <= 1'b0;
         v_on       <= 1'b0;
         line_odd_q <= 1'b0;
      end else if (px == h_total) begin
         // End of line
         px      <= '0;
         dispx_q <= '0;
         hsync_q <= 1'b1;
         de_q    <= 1'b0;
         if (py == v_total) begin
            py      <= '0;
            vsync_q <= 1'b1;
         end else begin
            py <= py + 1'b1;
            if (py == v_sync_off)
               vsync_q <= 1'b0;
         end
         // Next line is the first displayed one, which fills half 0
         if (py == v_disp_start) begin
            v_on       <= 1'b1;
            line_odd_q <= 1'b0;
         end else if (py == v_disp_end) begin
            v_on <= 1'b0;
         end else if (v_on) begin
            line_odd_q <= ~line_odd_q;
         end
      end else begin
         px      <= px + 1'b1;
         dispx_q <= de_q ? dispx_q + 1'b1 : '0;
         if (px == h_sync_off)
            hsync_q <= 1'b0;
         if (px == h_disp_start && v_on)
            de_q <= 1'b1;
         if (px == h_disp_end)
            de_q <= 1'b0;
      end
   end

   // hsync reloads high during hold but stays low until run
   assign scan.hsync    = hsync_q & i_run;
   assign scan.vsync    = vsync_q;
   assign scan.de       = de_q;
   assign scan.dispx    = dispx_q;
   assign scan.line_odd = line_odd_q;
   assign scan.depth    = depth_q;

endmodule

//--- hw/frame_resync.sv
// Resync handshake for the scan-out.
// i_sync_req is a toggle, the config must stay stable until o_sync_ack matches it.
// i_flyback is asynchronous; scan restarts on its falling edge after the hold.
// Scan is held from reset until the first request has been served.

`timescale 1ns/1ns

module frame_resync (
   input  logic pclk,
   input  logic reset,
   input  logic i_sync_req,
   input  logic i_flyback,
   output logic o_sync_ack,
   output logic o_run,
   output logic o_flyback_fall
);
   import video_pkg::*;

   logic [1:0]    req_sync;
   // Two-flop synchroniser plus the previous value for edge detect
   logic [2:0]    fb_sync;
   logic          req_pending;
   logic [1:0]    hold_ctr;
   resync_state_e state;

   always_ff @(posedge pclk) begin
      if (reset) begin
         req_sync <= '0;
         fb_sync  <= '0;
      end else begin
         req_sync <= {req_sync[0], i_sync_req};
         fb_sync  <= {fb_sync[1:0], i_flyback};
      end
   end

   // Request differs from the last ack, so a new config is waiting
   assign req_pending    = req_sync[1] != o_sync_ack;
   assign o_flyback_fall = fb_sync[2] & ~fb_sync[1];
   assign o_run          = state == RS_RUN;

   //////////////////////////////////////////////////////////////////////
   // Resync FSM

   always_ff @(posedge pclk) begin
      if (reset) begin
         state      <= RS_HOLD;
         hold_ctr   <= '0;
         o_sync_ack <= 1'b0;
      end else begin
         case (state)
            RS_RUN: begin
               // Drop run and give the generator three cycles to latch
               if (req_pending) begin
                  state    <= RS_HOLD;
                  hold_ctr <= 2'd2;
               end
            end
            RS_HOLD: begin
               if (hold_ctr != 2'd0)
                  hold_ctr <= hold_ctr - 2'd1;
               else if (req_pending)
                  state <= RS_WAIT_FLYBACK;
            end
            RS_WAIT_FLYBACK: begin
               // Missing an edge here only costs one frame
               if (o_flyback_fall) begin
                  state      <= RS_RUN;
                  o_sync_ack <= ~o_sync_ack;
               end
            end
            default: state <= RS_HOLD;
         endcase
      end
   end

endmodule

//--- hw/scan_if.sv
// Stage-0 scan position and syncs, as produced by the timing generator.
// All signals are registered in the pclk domain by the source side.

`timescale 1ns/1ns

interface scan_if #(
   parameter int ctr_w = video_pkg::CTR_W
) ();
   import video_pkg::*;

   logic             hsync;
   logic             vsync;
   logic             de;
   // Pixel index within the displayed line, 0 on the first de cycle
   logic [ctr_w-1:0] dispx;
   // Parity of the displayed line, selects the line-buffer half
   logic             line_odd;
   pix_depth_e       depth;

   // Timing generator
   modport source (output hsync, vsync, de, dispx, line_odd, depth);

   // Line-buffer read address
   modport fetch (input dispx, line_odd, depth);

   // Pixel pipeline
   modport sink (input hsync, vsync, de, dispx, depth);

endinterface

//--- hw/video_pkg.sv
// Shared widths, geometry constants and types for the video scan-out.
// One line of pixels must fit in one line-buffer half of LB_HALF_WORDS words.
// Palette entries are VIDC style, 4 bits per channel with red lowest.

package video_pkg;

   // Default width of the px/py counters and all geometry inputs
   localparam int CTR_W = 11;

   // Line buffer geometry, two halves of one line each
   localparam int LB_HALF_WORDS = 256;
   localparam int LB_ADDR_W     = $clog2(2 * LB_HALF_WORDS);

   // DMA and line-buffer word
   localparam int WORD_W = 32;

   // Output colour channel
   localparam int CHAN_W = 8;

   // Palette size, indexed by a 4-bit pixel value
   localparam int PAL_ENTRIES = 16;

   // One palette entry
   typedef struct packed {
      logic [3:0] blue;
      logic [3:0] green;
      logic [3:0] red;
   } pal_entry_t;

   typedef pal_entry_t [PAL_ENTRIES-1:0] palette_t;

   // Pixel depth, code is log2 of bits per pixel
   typedef enum logic [1:0] {
      PD_1BPP = 2'd0,
      PD_2BPP = 2'd1,
      PD_4BPP = 2'd2,
      PD_8BPP = 2'd3
   } pix_depth_e;

   // Scan resync FSM
   typedef enum logic [1:0] {
      RS_RUN          = 2'd0,
      RS_HOLD         = 2'd1,
      RS_WAIT_FLYBACK = 2'd2
   } resync_state_e;

endpackage
